// File: Bender.yml
package:
  name: lsu_mem

sources:
  - src/mem_cfg_pkg.sv
  - src/mem_types_pkg.sv
  - src/mem_if.sv
  - src/lsu_decode.sv
  - src/unaligned_ram.sv
  - src/load_result.sv
  - src/lsu_mem_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_lsu_mem.sv

// File: src/load_result.sv
// combinational load extension; load_data_o is only meaningful while load_valid_o is high
`timescale 1ns/1ps
`default_nettype none

module load_result
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    mem_rsp_if.res                  rsp,
    output logic                    load_valid_o,
    output logic [XLEN-1:0]         load_data_o
);
    // fill bit per size, zero for unsigned loads
    logic fill_b;
    logic fill_h;
    logic fill_w;

    assign fill_b = rsp.sign_ext && rsp.raw_data[7];
    assign fill_h = rsp.sign_ext && rsp.raw_data[15];
    assign fill_w = rsp.sign_ext && rsp.raw_data[31];

    assign load_valid_o = rsp.valid;

    // keep the low bytes, replicate fill above them
    always_comb begin
        case (rsp.size)
            SZ_B:    load_data_o = {{(XLEN-8){fill_b}}, rsp.raw_data[7:0]};
            SZ_H:    load_data_o = {{(XLEN-16){fill_h}}, rsp.raw_data[15:0]};
            SZ_W:    load_data_o = {{(XLEN-32){fill_w}}, rsp.raw_data[31:0]};
            default: load_data_o = rsp.raw_data;
        endcase
    end

endmodule

`default_nettype wire

// File: src/lsu_decode.sv
// combinational request decode; DEPTH_WORDS must be a power of two of at least 2, address bits above the array are ignored
`timescale 1ns/1ps
`default_nettype none

module lsu_decode
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
#(
    parameter int DEPTH_WORDS = DEPTH_WORDS_DEFAULT
) (
    input  wire logic               req_valid_i,
    input  wire logic               req_we_i,
    input  wire funct3_e            req_funct3_i,
    input  wire logic [ADDR_W-1:0]  req_addr_i,
    input  wire logic [XLEN-1:0]    req_wdata_i,
    mem_req_if.dec                  req
);
    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int WB    = XLEN / 8;

    // bytes touched, before the shift by offset
    logic [WB-1:0] size_mask;

    // strobes go straight through
    assign req.valid = req_valid_i;
    assign req.we    = req_we_i;

    // byte offset inside the word, then the word index above it
    assign req.offset   = req_addr_i[2:0];
    assign req.word_idx = req_addr_i[3 +: IDX_W];

    // signed and unsigned codes share a size
    always_comb begin
        case (req_funct3_i)
            F3_B, F3_BU: req.size = SZ_B;
            F3_H, F3_HU: req.size = SZ_H;
            F3_W, F3_WU: req.size = SZ_W;
            default:     req.size = SZ_D;
        endcase
    end

    // only the plain codes sign extend, double has nothing to fill
    assign req.sign_ext = (req_funct3_i inside {F3_B, F3_H, F3_W});

    always_comb begin
        case (req.size)
            SZ_B:    size_mask = 8'h01;
            SZ_H:    size_mask = 8'h03;
            SZ_W:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // mask moves by bytes, data by bits
    assign req.bmask_span = {{WB{1'b0}}, size_mask} << req.offset;
    // bytes above the access ride along but are masked off in the array
    assign req.wdata_span = {{XLEN{1'b0}}, req_wdata_i} << {req.offset, 3'b000};

endmodule

`default_nettype wire

// File: src/lsu_mem_top.sv
// data and instruction memory top; one request per cycle, load result one cycle later, DEPTH_WORDS a power of two
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
#(
    parameter int DEPTH_WORDS = DEPTH_WORDS_DEFAULT
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    // load/store request
    input  wire logic               req_valid_i,
    input  wire logic               req_we_i,
    input  wire funct3_e            req_funct3_i,
    input  wire logic [ADDR_W-1:0]  req_addr_i,
    input  wire logic [XLEN-1:0]    req_wdata_i,
    // fetch port
    input  wire logic [ADDR_W-1:0]  fetch_addr_i,
    // load result
    output logic                    load_valid_o,
    output logic [XLEN-1:0]         load_data_o,
    output logic [INST_W-1:0]       fetch_inst_o
);
    mem_req_if #(.DEPTH_WORDS(DEPTH_WORDS)) req_bus ();
    mem_rsp_if                              rsp_bus ();

    // decode
    lsu_decode #(.DEPTH_WORDS(DEPTH_WORDS)) u_decode (
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_funct3_i (req_funct3_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req          (req_bus.dec)
    );

    // array plus fetch
    unaligned_ram #(.DEPTH_WORDS(DEPTH_WORDS)) u_ram (
        .clk          (clk),
        .reset_i      (reset_i),
        .req          (req_bus.ram),
        .rsp          (rsp_bus.ram),
        .fetch_addr_i (fetch_addr_i),
        .fetch_inst_o (fetch_inst_o)
    );

    // sign or zero extension
    load_result u_result (
        .rsp          (rsp_bus.res),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o)
    );

endmodule

`default_nettype wire

// File: src/mem_cfg_pkg.sv
// width and depth constants; the word size is fixed at 64 bits and instructions at 32 bits
`default_nettype none

package mem_cfg_pkg;

    // data word of the rv64 core
    parameter int XLEN = 64;

    // byte address for both load/store and fetch
    parameter int ADDR_W = 32;

    // fetch returns one uncompressed instruction
    parameter int INST_W = 32;

    // two adjacent words, enough for any unaligned access
    parameter int SPAN_W = 2 * XLEN;

    // 32 KiB of storage unless the top level overrides it
    parameter int DEPTH_WORDS_DEFAULT = 4096;

endpackage

`default_nettype wire

// File: src/mem_if.sv
// request and load response buses between the memory stages; no handshake, valid is a 1-cycle strobe
`timescale 1ns/1ps
`default_nettype none

// decoded request, decode stage to array
interface mem_req_if
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
#(
    parameter int DEPTH_WORDS = DEPTH_WORDS_DEFAULT
) ();
    localparam int IDX_W = $clog2(DEPTH_WORDS);

    logic                   valid;
    logic                   we;
    // index of the lower of the two words
    logic [IDX_W-1:0]       word_idx;
    logic [2:0]             offset;
    // byte k of the span sits in the upper word for k >= 8
    logic [SPAN_W-1:0]      wdata_span;
    logic [SPAN_W/8-1:0]    bmask_span;
    access_size_e           size;
    logic                   sign_ext;

    modport dec (output valid, we, word_idx, offset, wdata_span, bmask_span, size, sign_ext);
    modport ram (input valid, we, word_idx, offset, wdata_span, bmask_span, size, sign_ext);
endinterface

// raw load data, array to result stage
interface mem_rsp_if
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
();
    logic                   valid;
    // already aligned down to byte 0
    logic [XLEN-1:0]        raw_data;
    access_size_e           size;
    logic                   sign_ext;

    modport ram (output valid, raw_data, size, sign_ext);
    modport res (input valid, raw_data, size, sign_ext);
endinterface

`default_nettype wire

// File: src/mem_types_pkg.sv
// access encodings; funct3 values follow the rv64i load/store opcodes, 3'b111 is not defined
`default_nettype none

package mem_types_pkg;

    // funct3 field of LOAD and STORE instructions
    // stores only use the low two bits, unsigned codes appear on loads
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_D  = 3'b011,
        F3_BU = 3'b100,
        F3_HU = 3'b101,
        F3_WU = 3'b110
    } funct3_e;

    // access width after decode
    // encoding equals funct3[1:0] so byte count is 1 << size
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } access_size_e;

endpackage

`default_nettype wire

// File: src/unaligned_ram.sv
// word array with unaligned access over two words; contents are not reset, the upper word wraps to index 0 at the top
`timescale 1ns/1ps
`default_nettype none

module unaligned_ram
    import mem_cfg_pkg::*;
#(
    parameter int DEPTH_WORDS = DEPTH_WORDS_DEFAULT
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    mem_req_if.ram                  req,
    mem_rsp_if.ram                  rsp,
    input  wire logic [ADDR_W-1:0]  fetch_addr_i,
    output logic [INST_W-1:0]       fetch_inst_o
);
    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int WB    = XLEN / 8;

    logic [XLEN-1:0]   mem_array [DEPTH_WORDS];

    // second word of the span, power-of-two depth wraps for free
    logic [IDX_W-1:0]  idx_hi;
    // load path
    logic              load_hit;
    logic [SPAN_W-1:0] rd_span;
    logic [SPAN_W-1:0] rd_shift;
    // fetch path
    logic [XLEN-1:0]   fetch_word;

    assign idx_hi   = req.word_idx + IDX_W'(1);
    assign load_hit = req.valid && !req.we;

    // byte-masked store into both words
    // low half of the span lands in word_idx, high half in the next word
    always_ff @(posedge clk) begin
        if (req.valid && req.we) begin
            for (int b = 0; b < WB; b++) begin
                if (req.bmask_span[b]) begin
                    mem_array[req.word_idx][8*b +: 8] <= req.wdata_span[8*b +: 8];
                end
                if (req.bmask_span[WB+b]) begin
                    mem_array[idx_hi][8*b +: 8] <= req.wdata_span[XLEN+8*b +: 8];
                end
            end
        end
    end

    // unaligned read
    // upper word on top, then drop the bytes below the offset
    assign rd_span  = {mem_array[idx_hi], mem_array[req.word_idx]};
    assign rd_shift = rd_span >> {req.offset, 3'b000};

    // response strobe, one cycle per accepted load
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= load_hit;
        end
    end

    // payload held between loads
    always_ff @(posedge clk) begin
        if (load_hit) begin
            rsp.raw_data <= rd_shift[XLEN-1:0];
            rsp.size     <= req.size;
            rsp.sign_ext <= req.sign_ext;
        end
    end

    // fetch port, combinational
    // bit 2 picks the instruction half of the word
    assign fetch_word = mem_array[fetch_addr_i[3 +: IDX_W]];

    always_comb begin
        if (fetch_addr_i[2]) begin
            fetch_inst_o = fetch_word[XLEN-1:INST_W];
        end else begin
            fetch_inst_o = fetch_word[INST_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// free-running clock from time 0; reset starts high and drops on a rising edge after RESET_CYCLES
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset held for a fixed count of rising edges
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end
endmodule

`default_nettype wire

// File: test/tb_lsu_mem.sv
// table-driven check of lsu_mem_top at 4096 words; only bytes written earlier in the table are read back
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_mem
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int DEPTH        = 4096;
    localparam int MODEL_BYTES  = DEPTH * 8;
    localparam logic [31:0] LFSR_SEED = 32'hbcf4df86;

    logic clk;
    logic reset_i;
    logic req_valid_i;
    logic req_we_i;
    funct3_e req_funct3_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [XLEN-1:0] req_wdata_i;
    logic [ADDR_W-1:0] fetch_addr_i;
    logic load_valid_o;
    logic [XLEN-1:0] load_data_o;
    logic [INST_W-1:0] fetch_inst_o;

    // stimulus table, one entry per request
    string t_name [$];
    logic t_we [$];
    funct3_e t_f3 [$];
    logic [ADDR_W-1:0] t_addr [$];
    logic [XLEN-1:0] t_data [$];
    logic t_rnd [$];
    logic [ADDR_W-1:0] t_faddr [$];
    logic table_ready = 1'b0;

    // byte-wide reference memory, wraps like the array
    logic [7:0] model_mem [MODEL_BYTES];
    logic [31:0] lfsr_state;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    lsu_mem_top #(.DEPTH_WORDS(DEPTH)) u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_funct3_i (req_funct3_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .fetch_addr_i (fetch_addr_i),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o),
        .fetch_inst_o (fetch_inst_o)
    );

    task automatic add_test(input string name, input logic we, input funct3_e f3,
                            input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] data,
                            input logic rnd, input logic [ADDR_W-1:0] faddr);
        t_name.push_back(name);
        t_we.push_back(we);
        t_f3.push_back(f3);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_rnd.push_back(rnd);
        t_faddr.push_back(faddr);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per data bit
    task automatic random_word(output logic [XLEN-1:0] w);
        for (int b = 0; b < XLEN; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[b] = lfsr_state[0];
        end
    endtask

    // bytes per access, unsigned codes same width as signed
    function automatic int size_bytes(input funct3_e f3);
        access_size_e sz;
        case (f3)
            F3_B, F3_BU: sz = SZ_B;
            F3_H, F3_HU: sz = SZ_H;
            F3_W, F3_WU: sz = SZ_W;
            default:     sz = SZ_D;
        endcase
        return 1 << int'(sz);
    endfunction

    task automatic store_model(input funct3_e f3, input logic [ADDR_W-1:0] addr,
                               input logic [XLEN-1:0] data);
        for (int k = 0; k < size_bytes(f3); k++) begin
            model_mem[(addr + k) & (MODEL_BYTES - 1)] = data[8*k +: 8];
        end
    endtask

    // little-endian gather, then sign or zero fill
    function automatic logic [XLEN-1:0] expected_load(input funct3_e f3,
                                                      input logic [ADDR_W-1:0] addr);
        logic [XLEN-1:0] val;
        logic fill;
        int nbytes;
        nbytes = size_bytes(f3);
        val = '0;
        for (int k = 0; k < nbytes; k++) begin
            val[8*k +: 8] = model_mem[(addr + k) & (MODEL_BYTES - 1)];
        end
        fill = (f3 inside {F3_B, F3_H, F3_W}) && val[8*nbytes-1];
        for (int k = 8 * nbytes; k < XLEN; k++) begin
            val[k] = fill;
        end
        return val;
    endfunction

    // low two address bits ignored, bit 2 picks the half
    function automatic logic [INST_W-1:0] expected_fetch(input logic [ADDR_W-1:0] faddr);
        logic [INST_W-1:0] inst;
        int base;
        base = int'(faddr & ~32'h3) & (MODEL_BYTES - 1);
        for (int k = 0; k < INST_W / 8; k++) begin
            inst[8*k +: 8] = model_mem[base + k];
        end
        return inst;
    endfunction

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected valid %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_inst(input string name, input logic [INST_W-1:0] exp,
                              input logic [INST_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected fetch %h, actual %h", name, exp, act));
        end
    endtask

    task automatic build_table();
        //        name            we  funct3 addr     data                    rnd fetch
        add_test("init_w0",      1, F3_D,  32'h000, 64'h0,                  1, 32'h000);
        add_test("init_w1",      1, F3_D,  32'h008, 64'h0,                  1, 32'h004);
        add_test("init_w2",      1, F3_D,  32'h010, 64'h0,                  1, 32'h008);
        add_test("ld_d_aligned", 0, F3_D,  32'h008, 64'h0,                  0, 32'h00c);
        // unaligned double and word, old bytes around them kept
        add_test("st_d_off3",    1, F3_D,  32'h003, 64'h0,                  1, 32'h000);
        add_test("ld_d_off3",    0, F3_D,  32'h003, 64'h0,                  0, 32'h004);
        add_test("ld_d_keep_lo", 0, F3_D,  32'h000, 64'h0,                  0, 32'h008);
        add_test("ld_d_keep_hi", 0, F3_D,  32'h008, 64'h0,                  0, 32'h00c);
        add_test("st_w_off6",    1, F3_W,  32'h00e, 64'h0,                  1, 32'h010);
        add_test("ld_wu_off6",   0, F3_WU, 32'h00e, 64'h0,                  0, 32'h014);
        add_test("ld_d_around",  0, F3_D,  32'h00c, 64'h0,                  0, 32'h008);
        add_test("st_d_off7",    1, F3_D,  32'h00f, 64'h0123456789abcdef, 0, 32'h00c);
        add_test("ld_d_off7",    0, F3_D,  32'h00f, 64'h0,                  0, 32'h014);
        // narrow stores, upper data bytes must not land
        add_test("st_b_off5",    1, F3_B,  32'h005, 64'hffffffffffffff80, 0, 32'h004);
        add_test("st_h_off2",    1, F3_H,  32'h002, 64'hffffffffffff8001, 0, 32'h000);
        add_test("st_bu_off1",   1, F3_BU, 32'h001, 64'hffffffffffffffa5, 0, 32'h000);
        add_test("st_hu_off7",   1, F3_HU, 32'h007, 64'h123456789abcdef0, 0, 32'h008);
        add_test("ld_d_merge0",  0, F3_D,  32'h000, 64'h0,                  0, 32'h004);
        add_test("ld_d_merge1",  0, F3_D,  32'h008, 64'h0,                  0, 32'h00c);
        // sign and zero extension
        add_test("st_d_signs",   1, F3_D,  32'h018, 64'h88776655f4f3f2f1, 0, 32'h018);
        add_test("ld_b",         0, F3_B,  32'h018, 64'h0,                  0, 32'h01c);
        add_test("ld_bu",        0, F3_BU, 32'h018, 64'h0,                  0, 32'h018);
        add_test("ld_h",         0, F3_H,  32'h018, 64'h0,                  0, 32'h01c);
        add_test("ld_hu",        0, F3_HU, 32'h018, 64'h0,                  0, 32'h010);
        add_test("ld_w",         0, F3_W,  32'h018, 64'h0,                  0, 32'h014);
        add_test("ld_wu",        0, F3_WU, 32'h018, 64'h0,                  0, 32'h01c);
        add_test("ld_b_pos",     0, F3_B,  32'h01e, 64'h0,                  0, 32'h018);
        add_test("ld_w_cross",   0, F3_W,  32'h016, 64'h0,                  0, 32'h010);
    endtask

    // 20 cycles per entry plus reset
    initial begin
        wait (table_ready);
        #((t_name.size() * 20 + RESET_CYCLES + 4) * CLK_PERIOD);
        abort_run("watchdog expired before the stimulus table finished");
    end

    initial begin
        logic [XLEN-1:0] wdata;
        req_valid_i  = 1'b0;
        req_we_i     = 1'b0;
        req_funct3_i = F3_D;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        fetch_addr_i = '0;
        lfsr_state   = LFSR_SEED;
        build_table();
        table_ready = 1'b1;

        // a load held through reset must not raise the strobe
        @(posedge clk);
        req_valid_i <= 1'b1;
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_valid("reset", 1'b0, load_valid_o);
        end
        // load dropped on the edge where reset releases
        @(posedge clk);
        req_valid_i <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_valid("reset", 1'b0, load_valid_o);
        end
        if (reset_i !== 1'b0) begin
            abort_run("reset did not release after the expected number of cycles");
        end

        foreach (t_name[i]) begin
            if (t_rnd[i]) begin
                random_word(wdata);
            end else begin
                wdata = t_data[i];
            end
            @(posedge clk);
            req_valid_i  <= 1'b1;
            req_we_i     <= t_we[i];
            req_funct3_i <= t_f3[i];
            req_addr_i   <= t_addr[i];
            req_wdata_i  <= wdata;
            fetch_addr_i <= t_faddr[i];
            // request taken at this edge
            @(posedge clk);
            req_valid_i <= 1'b0;
            if (t_we[i]) begin
                store_model(t_f3[i], t_addr[i], wdata);
            end
            @(negedge clk);
            check_valid(t_name[i], !t_we[i], load_valid_o);
            if (!t_we[i]) begin
                check_data(t_name[i], expected_load(t_f3[i], t_addr[i]), load_data_o);
            end
            check_inst(t_name[i], expected_fetch(t_faddr[i]), fetch_inst_o);
            // strobe lasts one cycle only
            @(negedge clk);
            check_valid(t_name[i], 1'b0, load_valid_o);
        end

        $display("Result: PASSED");
        $finish;
    end
endmodule

`default_nettype wire

// File: verilog.f
src/mem_cfg_pkg.sv
src/mem_types_pkg.sv
src/mem_if.sv
src/lsu_decode.sv
src/unaligned_ram.sv
src/load_result.sv
src/lsu_mem_top.sv
test/tb_clk_gen.sv
test/tb_lsu_mem.sv
